// File: source/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Width of the shared bus and of every bus register.
`define WORD_WIDTH 8

// Instruction opcode width.
`define OPCODE_WIDTH 4

// Micro-op step counter width, eight steps per opcode.
`define STEP_WIDTH 3

// Microcode address is the opcode above the step.
`define UCODE_ADDR_WIDTH 7

// Width of one stored control word.
`define UCODE_WIDTH 16

// Number of general bus registers.
`define NUM_REGS 4

`endif

// File: source/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

  // One word on the bus.
  typedef logic [`WORD_WIDTH-1:0] word_t;
  // Instruction opcode.
  typedef logic [`OPCODE_WIDTH-1:0] opcode_t;
  // Micro-op step within an instruction.
  typedef logic [`STEP_WIDTH-1:0] step_t;
  // Microcode address, {opcode, step}.
  typedef logic [`UCODE_ADDR_WIDTH-1:0] ucode_addr_t;
  // Control word, out plane in [2:0], in plane in [5:3], ALU op in [8:6], step reset in [9].
  typedef logic [`UCODE_WIDTH-1:0] ucode_word_t;

  // Bus drivers. Value 7 is not a legal encoding.
  typedef enum logic [2:0] {
    OUT_NONE  = 3'd0,
    OUT_REG0  = 3'd1,
    OUT_REG1  = 3'd2,
    OUT_REG2  = 3'd3,
    OUT_REG3  = 3'd4,
    OUT_ALU   = 3'd5,
    OUT_INPUT = 3'd6
  } out_plane_e;

  // Register load targets. Values 5 to 7 are not legal.
  typedef enum logic [2:0] {
    IN_NONE = 3'd0,
    IN_REG0 = 3'd1,
    IN_REG1 = 3'd2,
    IN_REG2 = 3'd3,
    IN_REG3 = 3'd4
  } in_plane_e;

  // ALU operations.
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_ADC = 3'd1,
    ALU_SUB = 3'd2,
    ALU_AND = 3'd3,
    ALU_OR  = 3'd4,
    ALU_XOR = 3'd5,
    ALU_SHL = 3'd6,
    ALU_SHR = 3'd7
  } alu_op_e;

endpackage

// File: source/control_logic.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module control_logic (
  input  logic                       N_CLK,
  input  logic                       N_RST,
  input  cpu_pkg::opcode_t           opcode,
  input  logic                       boot_we,
  input  cpu_pkg::ucode_addr_t       boot_addr,
  input  cpu_pkg::ucode_word_t       boot_data,
  input  logic                       booted,
  output logic [`NUM_REGS-1:0]       reg_load,
  output logic [`NUM_REGS-1:0]       reg_drive,
  output logic                       alu_drive,
  output logic                       input_drive,
  output cpu_pkg::alu_op_e           alu_op
);

  // Microcode store, one word per {opcode, step}.
  cpu_pkg::ucode_word_t ucode_mem [0:(1 << `UCODE_ADDR_WIDTH)-1];

  cpu_pkg::step_t       step;
  cpu_pkg::ucode_addr_t fetch_addr;
  cpu_pkg::ucode_word_t fetch_word;
  // Registered control word, drives the planes for one cycle.
  cpu_pkg::ucode_word_t ctrl_word;
  cpu_pkg::out_plane_e  out_plane;
  cpu_pkg::in_plane_e   in_plane;

  // Bootstrap port. Only open before boot.
  always_ff @(posedge N_CLK) begin
    if (!booted && boot_we) begin
      ucode_mem[boot_addr] <= boot_data;
    end
  end

  // Opcode selects the program, step selects the word in it.
  assign fetch_addr = {opcode, step};
  assign fetch_word = ucode_mem[fetch_addr];

  // Fetch stage.
  always_ff @(posedge N_CLK or negedge N_RST) begin
    if (!N_RST) begin
      step      <= '0;
      ctrl_word <= '0;
    end else if (!booted) begin
      // Hold at the start of the program with no controls active.
      step      <= '0;
      ctrl_word <= '0;
    end else begin
      ctrl_word <= fetch_word;
      // Misc bit restarts the program on the next fetch.
      step      <= fetch_word[9] ? '0 : cpu_pkg::step_t'(step + 1'b1);
    end
  end

  // Plane fields.
  assign out_plane = cpu_pkg::out_plane_e'(ctrl_word[2:0]);
  assign in_plane  = cpu_pkg::in_plane_e'(ctrl_word[5:3]);
  assign alu_op    = cpu_pkg::alu_op_e'(ctrl_word[8:6]);

  // Plane decoders.
  // Illegal codes match no target, so nothing fires.
  always_comb begin
    reg_load  = '0;
    reg_drive = '0;
    for (int i = 0; i < `NUM_REGS; i++) begin
      reg_load[i]  = (in_plane == cpu_pkg::in_plane_e'(int'(cpu_pkg::IN_REG0) + i));
      reg_drive[i] = (out_plane == cpu_pkg::out_plane_e'(int'(cpu_pkg::OUT_REG0) + i));
    end
  end

  assign alu_drive   = (out_plane == cpu_pkg::OUT_ALU);
  assign input_drive = (out_plane == cpu_pkg::OUT_INPUT);

  // The store is frozen once the core runs.
  a_no_write_after_boot: assert property (
    @(posedge N_CLK) disable iff (!N_RST) booted |-> !boot_we);

  // A register never loads its own output.
  a_no_load_and_drive: assert property (
    @(posedge N_CLK) disable iff (!N_RST) (reg_load & reg_drive) == '0);

  // Out plane code 7 is never programmed.
  a_out_plane_legal: assert property (
    @(posedge N_CLK) disable iff (!N_RST) ctrl_word[2:0] != 3'd7);

endmodule

// File: source/bus_register.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module bus_register (
  input  logic           N_CLK,
  input  logic           N_RST,
  input  logic           load,
  input  cpu_pkg::word_t bus,
  output cpu_pkg::word_t value
);

  // Loads at the edge that ends the micro-op cycle.
  always_ff @(posedge N_CLK or negedge N_RST) begin
    if (!N_RST) begin
      value <= '0;
    end else if (load) begin
      value <= bus;
    end
  end

  // Contents only move on a load strobe.
  a_hold_without_load: assert property (
    @(posedge N_CLK) disable iff (!N_RST) !load |=> $stable(value));

endmodule

// File: source/alu_unit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu_unit (
  input  logic             N_CLK,
  input  logic             N_RST,
  input  cpu_pkg::word_t   operand_a,
  input  cpu_pkg::word_t   operand_b,
  input  cpu_pkg::alu_op_e alu_op,
  input  logic             alu_drive,
  output cpu_pkg::word_t   result,
  output logic             carry
);

  // Top bit is the next carry, lower bits the result.
  logic [`WORD_WIDTH:0] wide;

  always_comb begin
    wide = '0;
    case (alu_op)
      cpu_pkg::ALU_ADD: wide = {1'b0, operand_a} + {1'b0, operand_b};
      // Add with the stored carry.
      cpu_pkg::ALU_ADC: wide = {1'b0, operand_a} + {1'b0, operand_b} +
                               {{`WORD_WIDTH{1'b0}}, carry};
      // Two's complement. Carry out means no borrow, a >= b.
      cpu_pkg::ALU_SUB: wide = {1'b0, operand_a} + {1'b0, ~operand_b} +
                               {{`WORD_WIDTH{1'b0}}, 1'b1};
      // Logic ops clear carry.
      cpu_pkg::ALU_AND: wide = {1'b0, operand_a & operand_b};
      cpu_pkg::ALU_OR:  wide = {1'b0, operand_a | operand_b};
      cpu_pkg::ALU_XOR: wide = {1'b0, operand_a ^ operand_b};
      // Top bit falls into carry.
      cpu_pkg::ALU_SHL: wide = {operand_a, 1'b0};
      // Bottom bit falls into carry, zero shifted in.
      cpu_pkg::ALU_SHR: wide = {operand_a[0], 1'b0, operand_a[`WORD_WIDTH-1:1]};
      default:          wide = '0;
    endcase
  end

  assign result = wide[`WORD_WIDTH-1:0];

  // Flag is only touched by a cycle where the ALU owns the bus.
  always_ff @(posedge N_CLK or negedge N_RST) begin
    if (!N_RST) begin
      carry <= 1'b0;
    end else if (alu_drive) begin
      carry <= wide[`WORD_WIDTH];
    end
  end

endmodule

// File: source/bus_mux.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module bus_mux (
  input  logic                             N_CLK,
  input  logic                             N_RST,
  input  cpu_pkg::word_t [`NUM_REGS-1:0]   reg_values,
  input  logic [`NUM_REGS-1:0]             reg_drive,
  input  cpu_pkg::word_t                   alu_result,
  input  logic                             alu_drive,
  input  cpu_pkg::word_t                   data_in,
  input  logic                             input_drive,
  output cpu_pkg::word_t                   bus
);

  // AND-OR bus. An idle bus reads as zero.
  always_comb begin
    bus = '0;
    for (int i = 0; i < `NUM_REGS; i++) begin
      bus = bus | (reg_values[i] & {`WORD_WIDTH{reg_drive[i]}});
    end
    bus = bus | (alu_result & {`WORD_WIDTH{alu_drive}});
    bus = bus | (data_in & {`WORD_WIDTH{input_drive}});
  end

  // Two drivers would OR their words together.
  a_single_driver: assert property (
    @(posedge N_CLK) disable iff (!N_RST) $onehot0({reg_drive, alu_drive, input_drive}));

endmodule

// File: source/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_core (
  input  logic                 N_CLK,
  input  logic                 N_RST,
  input  logic                 boot_we,
  input  cpu_pkg::ucode_addr_t boot_addr,
  input  cpu_pkg::ucode_word_t boot_data,
  input  logic                 booted,
  input  cpu_pkg::opcode_t     opcode,
  input  cpu_pkg::word_t       data_in,
  output cpu_pkg::word_t       bus,
  output logic                 carry
);

  // Per-register strobes from the decoders.
  logic [`NUM_REGS-1:0]           reg_load;
  logic [`NUM_REGS-1:0]           reg_drive;
  logic                           alu_drive;
  logic                           input_drive;
  cpu_pkg::alu_op_e               alu_op;
  cpu_pkg::word_t [`NUM_REGS-1:0] reg_values;
  cpu_pkg::word_t                 alu_result;

  control_logic u_control_logic (
    .N_CLK       (N_CLK),
    .N_RST       (N_RST),
    .opcode      (opcode),
    .boot_we     (boot_we),
    .boot_addr   (boot_addr),
    .boot_data   (boot_data),
    .booted      (booted),
    .reg_load    (reg_load),
    .reg_drive   (reg_drive),
    .alu_drive   (alu_drive),
    .input_drive (input_drive),
    .alu_op      (alu_op)
  );

  // Register file, all on the shared bus.
  for (genvar i = 0; i < `NUM_REGS; i++) begin : g_reg
    bus_register u_bus_register (
      .N_CLK (N_CLK),
      .N_RST (N_RST),
      .load  (reg_load[i]),
      .bus   (bus),
      .value (reg_values[i])
    );
  end

  // Registers 0 and 1 are the fixed ALU operands.
  alu_unit u_alu_unit (
    .N_CLK     (N_CLK),
    .N_RST     (N_RST),
    .operand_a (reg_values[0]),
    .operand_b (reg_values[1]),
    .alu_op    (alu_op),
    .alu_drive (alu_drive),
    .result    (alu_result),
    .carry     (carry)
  );

  bus_mux u_bus_mux (
    .N_CLK       (N_CLK),
    .N_RST       (N_RST),
    .reg_values  (reg_values),
    .reg_drive   (reg_drive),
    .alu_result  (alu_result),
    .alu_drive   (alu_drive),
    .data_in     (data_in),
    .input_drive (input_drive),
    .bus         (bus)
  );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic N_CLK,
  output logic N_RST
);

  // Free running clock, low at time zero.
  initial begin
    N_CLK = 1'b0;
    forever #(PERIOD_NS / 2) N_CLK = ~N_CLK;
  end

  // Release reset just after an edge so it never races the flops.
  initial begin
    N_RST = 1'b0;
    repeat (RESET_CYCLES) @(posedge N_CLK);
    #1;
    N_RST = 1'b1;
  end

endmodule

// File: tests/cpu_core_tb.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_core_tb;

  localparam int PERIOD_NS    = 100;
  localparam int RESET_CYCLES = 16;
  localparam int PROG_STEPS   = 3;
  localparam int NUM_PROGS    = 9;
  localparam int NUM_DIRECTED = 11;
  localparam int NUM_RANDOM   = 24;
  // Worst case, every random program runs twice.
  localparam int TEST_CYCLES  = RESET_CYCLES + NUM_PROGS * PROG_STEPS + 4 +
                                (NUM_DIRECTED + 2 * NUM_RANDOM) * PROG_STEPS;
  localparam int TIMEOUT_NS   = (TEST_CYCLES + 20) * PERIOD_NS;

  logic                 N_CLK;
  logic                 N_RST;
  logic                 boot_we;
  cpu_pkg::ucode_addr_t boot_addr;
  cpu_pkg::ucode_word_t boot_data;
  logic                 booted;
  cpu_pkg::opcode_t     opcode;
  cpu_pkg::word_t       data_in;
  cpu_pkg::word_t       bus;
  logic                 carry;

  // Reference model state.
  cpu_pkg::ucode_word_t ucode_model [0:(1 << `UCODE_ADDR_WIDTH)-1];
  cpu_pkg::ucode_word_t m_ctrl;
  cpu_pkg::step_t       m_step;
  cpu_pkg::word_t       m_regs [`NUM_REGS];
  logic                 m_carry;

  logic [15:0] lfsr;
  int          errors;
  int          checks;

  tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_tb_clock (
    .N_CLK (N_CLK),
    .N_RST (N_RST)
  );

  cpu_core u_cpu_core (
    .N_CLK     (N_CLK),
    .N_RST     (N_RST),
    .boot_we   (boot_we),
    .boot_addr (boot_addr),
    .boot_data (boot_data),
    .booted    (booted),
    .opcode    (opcode),
    .data_in   (data_in),
    .bus       (bus),
    .carry     (carry)
  );

  // Galois LFSR, 16 bits.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken.
  function automatic cpu_pkg::word_t rand_bits(input int n);
    cpu_pkg::word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // Field layout: out [2:0], in [5:3], ALU op [8:6], step reset [9].
  function automatic cpu_pkg::ucode_word_t make_word(input logic [2:0] out_sel,
                                                     input logic [2:0] in_sel,
                                                     input logic [2:0] alu_sel,
                                                     input logic       restart);
    return {6'b0, restart, alu_sel, in_sel, out_sel};
  endfunction

  // Expected {carry, result} of one ALU op.
  function automatic logic [8:0] alu_ref(input logic [2:0] op, input cpu_pkg::word_t a,
                                         input cpu_pkg::word_t b, input logic cin);
    logic [8:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    case (op)
      cpu_pkg::ALU_ADD: alu_ref = sum;
      cpu_pkg::ALU_ADC: alu_ref = sum + 9'(cin);
      // Carry set means no borrow.
      cpu_pkg::ALU_SUB: alu_ref = {a >= b, 8'(a - b)};
      cpu_pkg::ALU_AND: alu_ref = {1'b0, a & b};
      cpu_pkg::ALU_OR:  alu_ref = {1'b0, a | b};
      cpu_pkg::ALU_XOR: alu_ref = {1'b0, a ^ b};
      cpu_pkg::ALU_SHL: alu_ref = {a[7], a[6:0], 1'b0};
      default:          alu_ref = {a[0], 1'b0, a[7:1]};
    endcase
  endfunction

  // Bus value for the current control word, zero when idle.
  function automatic cpu_pkg::word_t expected_bus(input cpu_pkg::ucode_word_t ctrl,
                                                  input cpu_pkg::word_t din);
    logic [8:0] alu_v;
    alu_v = alu_ref(ctrl[8:6], m_regs[0], m_regs[1], m_carry);
    case (ctrl[2:0])
      3'd1, 3'd2, 3'd3, 3'd4: expected_bus = m_regs[ctrl[2:0] - 3'd1];
      3'd5:    expected_bus = alu_v[7:0];
      3'd6:    expected_bus = din;
      default: expected_bus = '0;
    endcase
  endfunction

  // Writes all nine programs through the bootstrap port.
  task automatic load_microcode();
    cpu_pkg::ucode_word_t words [PROG_STEPS];
    for (int op = 0; op < NUM_PROGS; op++) begin
      if (op < 8) begin
        words[0] = make_word(cpu_pkg::OUT_INPUT, cpu_pkg::IN_REG0, 3'd0, 1'b0);
        words[1] = make_word(cpu_pkg::OUT_INPUT, cpu_pkg::IN_REG1, 3'd0, 1'b0);
        words[2] = make_word(cpu_pkg::OUT_ALU, cpu_pkg::IN_NONE, 3'(op), 1'b1);
      end else begin
        // Move chain through REG2 and REG3.
        words[0] = make_word(cpu_pkg::OUT_INPUT, cpu_pkg::IN_REG2, 3'd0, 1'b0);
        words[1] = make_word(cpu_pkg::OUT_REG2, cpu_pkg::IN_REG3, 3'd0, 1'b0);
        words[2] = make_word(cpu_pkg::OUT_REG3, cpu_pkg::IN_NONE, 3'd0, 1'b1);
      end
      for (int s = 0; s < PROG_STEPS; s++) begin
        @(posedge N_CLK);
        #1;
        boot_we   = 1'b1;
        boot_addr = {cpu_pkg::opcode_t'(op), cpu_pkg::step_t'(s)};
        boot_data = words[s];
        ucode_model[boot_addr] = words[s];
      end
    end
    @(posedge N_CLK);
    #1;
    boot_we = 1'b0;
  endtask

  // One pass through a program; entered with step at 0.
  task automatic run_program(input cpu_pkg::opcode_t op, input cpu_pkg::word_t a,
                             input cpu_pkg::word_t b);
    opcode = op;
    for (int s = 0; s < PROG_STEPS; s++) begin
      @(posedge N_CLK);
      #1;
      if (s == 0) begin
        data_in = a;
      end else if (s == 1) begin
        data_in = b;
      end else begin
        data_in = rand_bits(8);
      end
    end
  endtask

  // Compare mid-cycle, then step the model over the next rising edge.
  always @(negedge N_CLK) begin
    cpu_pkg::word_t bus_v;
    logic [8:0]     alu_v;
    if (!N_RST) begin
      m_ctrl  = '0;
      m_step  = '0;
      m_carry = 1'b0;
      for (int i = 0; i < `NUM_REGS; i++) begin
        m_regs[i] = '0;
      end
    end else begin
      bus_v = expected_bus(m_ctrl, data_in);
      alu_v = alu_ref(m_ctrl[8:6], m_regs[0], m_regs[1], m_carry);
      checks++;
      if (bus !== bus_v) begin
        errors++;
        $display("** Error: bus expected 0x%02h actual 0x%02h at %0t", bus_v, bus, $time);
      end
      if (carry !== m_carry) begin
        errors++;
        $display("** Error: carry expected 0x%0h actual 0x%0h at %0t", m_carry, carry, $time);
      end
      // Destination loads what the bus carries this cycle.
      if (m_ctrl[5:3] >= 3'd1 && m_ctrl[5:3] <= 3'd4) begin
        m_regs[m_ctrl[5:3] - 3'd1] = bus_v;
      end
      if (m_ctrl[2:0] == 3'd5) begin
        m_carry = alu_v[8];
      end
      if (!booted) begin
        m_ctrl = '0;
        m_step = '0;
      end else begin
        m_ctrl = ucode_model[{opcode, m_step}];
        m_step = m_ctrl[9] ? '0 : cpu_pkg::step_t'(m_step + 1'b1);
      end
    end
  end

  initial begin
    cpu_pkg::opcode_t op;
    int               reps;
    boot_we    = 1'b0;
    boot_addr  = '0;
    boot_data  = '0;
    booted     = 1'b0;
    opcode     = '0;
    data_in    = '0;
    errors     = 0;
    checks     = 0;
    lfsr       = 16'd52;
    wait (N_RST === 1'b1);
    load_microcode();
    booted = 1'b1;
    // ADD overflow, then ADC picks up the carry.
    run_program(4'd0, 8'hC0, 8'h80);
    run_program(4'd1, 8'h10, 8'h20);
    // SUB above, below and equal.
    run_program(4'd2, 8'h50, 8'h30);
    run_program(4'd2, 8'h30, 8'h50);
    run_program(4'd2, 8'h44, 8'h44);
    run_program(4'd6, 8'h81, 8'h00);
    run_program(4'd7, 8'h03, 8'h00);
    run_program(4'd3, 8'hF0, 8'h3C);
    run_program(4'd4, 8'hF0, 8'h3C);
    run_program(4'd5, 8'hF0, 8'h3C);
    run_program(4'd8, 8'hA5, 8'h00);
    // Random opcodes, sometimes held for a second pass.
    for (int i = 0; i < NUM_RANDOM; i++) begin
      op = cpu_pkg::opcode_t'(rand_bits(4));
      if (op > 4'd8) begin
        op = op - 4'd8;
      end
      reps = 1 + int'(rand_bits(1));
      repeat (reps) run_program(op, rand_bits(8), rand_bits(8));
    end
    repeat (2) @(posedge N_CLK);
    #1;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    #(TIMEOUT_NS);
    $display("run timed out after %0d ns", TIMEOUT_NS);
    $display("test failed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+source
source/cpu_pkg.sv
source/control_logic.sv
source/bus_register.sv
source/alu_unit.sv
source/bus_mux.sv
source/cpu_core.sv
tests/tb_clock.sv
tests/cpu_core_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cpu_core_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

# Build, run, and pass only if the pass line is printed.
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
